//--- source/vision_pkg.sv
// Shared pixel path types; RGB444 only, one camera bus layout, four filter modes
package vision_pkg;

	// One RGB444 pixel, red in the top nibble
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} pixel_t;

	// One stream beat, ready runs the other way
	typedef struct packed {
		pixel_t data;
		logic   sop;   // First pixel of frame
		logic   eop;   // Last pixel of frame
		logic   valid;
	} pix_stream_t;

	// OV7670 style parallel bus
	typedef struct packed {
		logic       vsync;
		logic       href;
		logic [7:0] data;
	} cam_bus_t;

	// Key index maps straight onto mode value
	typedef enum logic [1:0] {
		filt_pass   = 2'd0,
		filt_gray   = 2'd1,
		filt_invert = 2'd2,
		filt_tone   = 2'd3
	} filter_mode_t;

	// Pitch detector result, picks the kept channel in tone mode
	typedef enum logic [1:0] {
		tone_red   = 2'd0,
		tone_green = 2'd1,
		tone_blue  = 2'd2,
		tone_all   = 2'd3
	} freq_flag_t;

endpackage

//--- source/pixel_capture.sv
// Expects two bytes per pixel with red in the first low nibble; no back-pressure, one frame per vsync
`timescale 1ns/1ps
module pixel_capture import vision_pkg::*; #(
	parameter int H_PIXELS = 640,
	parameter int V_LINES  = 480
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  cam_bus_t                                cam,
	output logic                                    wr_en,
	output logic [$clog2(H_PIXELS*V_LINES)-1:0]     wr_addr,
	output pixel_t                                  wr_pixel,
	output logic                                    frame_done
);
	localparam int PIXELS = H_PIXELS * V_LINES;
	localparam int AW     = $clog2(PIXELS);

	logic          armed;   // Set by vsync, cleared at full frame
	logic          second;  // Byte phase within a pixel
	logic [3:0]    red_q;   // Red nibble from first byte
	logic [AW-1:0] count;   // Row-major pixel index

	// Write goes out in the same cycle as the second byte
	assign wr_en    = armed && !cam.vsync && cam.href && second;
	assign wr_addr  = count;
	assign wr_pixel = '{r: red_q, g: cam.data[7:4], b: cam.data[3:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			armed      <= 1'b0;
			second     <= 1'b0;
			count      <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;  // Single cycle pulse
			if (cam.vsync) begin
				armed  <= 1'b1;   // New frame, start over
				second <= 1'b0;
				count  <= '0;
			end else if (!cam.href) begin
				second <= 1'b0;   // Line gap realigns byte phase
			end else if (armed) begin
				second <= !second;
				if (wr_en) begin
					count <= count + 1'b1;
					if (count == AW'(PIXELS - 1)) begin
						armed      <= 1'b0;  // Deaf until next vsync
						frame_done <= 1'b1;
					end
				end
			end
		end
	end

	// Hold red until its partner byte shows up
	always_ff @(posedge clk) begin
		if (cam.href && !second)
			red_q <= cam.data[3:0];
	end

endmodule

//--- source/frame_buffer.sv
// Single frame store; read data valid one cycle after rd_en, write and read of one address undefined
`timescale 1ns/1ps
module frame_buffer import vision_pkg::*; #(
	parameter int DEPTH = 640 * 480
) (
	input  logic                     clk,
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  pixel_t                   wr_pixel,
	input  logic                     rd_en,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output pixel_t                   rd_pixel
);

	// Maps onto block RAM
	pixel_t mem [DEPTH];

	// Camera side write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_pixel;
	end

	// Registered read, output held while rd_en low
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_pixel <= mem[rd_addr];  // Holds last word under stall
	end

endmodule

//--- source/address_generator.sv
// Reads one stored frame per frame_done; a frame_done seen while busy is dropped
`timescale 1ns/1ps
module address_generator import vision_pkg::*; #(
	parameter int H_PIXELS = 640,
	parameter int V_LINES  = 480
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                frame_done,
	output logic                                rd_en,
	output logic [$clog2(H_PIXELS*V_LINES)-1:0] rd_addr,
	input  pixel_t                              rd_pixel,
	output pix_stream_t                         src,
	input  logic                                ready
);
	localparam int PIXELS = H_PIXELS * V_LINES;
	localparam int AW     = $clog2(PIXELS);

	typedef enum logic [1:0] {
		st_idle,
		st_prime,   // RAM register holds pixel 0
		st_stream
	} state_t;

	state_t        state;
	logic [AW-1:0] ram_addr;   // Address now sitting in RAM register
	logic          ram_valid;  // RAM register holds an unsent pixel
	logic          rd_done;    // Last address already read
	logic          advance;    // Output register free this cycle
	logic          take;

	assign take    = src.valid && ready;
	assign advance = !src.valid || ready;

	// Read only when the RAM register can move forward
	always_comb begin
		case (state)
			st_idle: rd_en = frame_done;
			default: rd_en = advance && !rd_done;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			rd_addr   <= '0;
			ram_addr  <= '0;
			ram_valid <= 1'b0;
			rd_done   <= 1'b0;
			src       <= '0;
		end else begin
			if (rd_en) begin
				ram_addr <= rd_addr;
				rd_addr  <= rd_addr + 1'b1;
				rd_done  <= (rd_addr == AW'(PIXELS - 1));
			end
			case (state)
				st_idle: begin
					if (frame_done) begin
						state     <= st_prime;
						ram_valid <= 1'b1;  // Address 0 in flight
					end
				end
				default: begin
					if (advance) begin
						src.valid <= ram_valid;  // Drains to empty after last
						src.data  <= rd_pixel;
						src.sop   <= (ram_addr == '0);
						src.eop   <= (ram_addr == AW'(PIXELS - 1));
						ram_valid <= rd_en;
					end
					if (state == st_prime)
						state <= st_stream;
				end
			endcase
			// Frame finished once eop leaves
			if (take && src.eop) begin
				state   <= st_idle;
				rd_addr <= '0;
				rd_done <= 1'b0;
			end
		end
	end

endmodule

//--- source/filter_control.sv
// Keys are active low and asynchronous; lowest pressed key wins, mode holds until next press
`timescale 1ns/1ps
module filter_control import vision_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic [3:0]   key,
	output filter_mode_t mode
);

	logic [3:0] key_meta;  // First sync stage
	logic [3:0] key_sync;  // Safe to use
	logic [3:0] key_prev;  // For edge detect
	logic [3:0] press;     // One cycle per falling edge

	always_ff @(posedge clk) begin
		if (reset) begin
			key_meta <= 4'hF;  // Released
			key_sync <= 4'hF;
			key_prev <= 4'hF;
		end else begin
			key_meta <= key;
			key_sync <= key_meta;
			key_prev <= key_sync;
		end
	end

	// High to low on the synced key
	assign press = key_prev & ~key_sync;

	// Mode register, priority to key 0
	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= filt_pass;
		end else begin
			if (press[0])
				mode <= filt_pass;
			else if (press[1])
				mode <= filt_gray;
			else if (press[2])
				mode <= filt_invert;
			else if (press[3])
				mode <= filt_tone;
		end
	end

endmodule

//--- source/filter_select.sv
// One-stage filter; mode and freq_flag sampled per accepted pixel, sop and eop passed as is
`timescale 1ns/1ps
module filter_select import vision_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  filter_mode_t mode,
	input  freq_flag_t   freq_flag,
	input  pix_stream_t  snk,
	output logic         snk_ready,
	output pix_stream_t  src,
	input  logic         src_ready
);

	logic   load;      // Output register takes a new beat
	pixel_t filtered;  // Result for the incoming pixel

	// Free slot or draining slot
	assign load      = !src.valid || src_ready;
	assign snk_ready = load;

	always_comb begin
		logic [5:0] sum;  // r + 2g + b, max 60
		sum      = {2'b00, snk.data.r} + {1'b0, snk.data.g, 1'b0} + {2'b00, snk.data.b};
		filtered = snk.data;
		case (mode)
			filt_pass: filtered = snk.data;
			filt_gray: begin
				filtered.r = sum[5:2];  // Divide by 4, truncate
				filtered.g = sum[5:2];
				filtered.b = sum[5:2];
			end
			filt_invert: begin
				filtered.r = 4'hF - snk.data.r;
				filtered.g = 4'hF - snk.data.g;
				filtered.b = 4'hF - snk.data.b;
			end
			filt_tone: begin
				// Keep only the channel named by the pitch result
				case (freq_flag)
					tone_red:   filtered = '{r: snk.data.r, g: 4'h0, b: 4'h0};
					tone_green: filtered = '{r: 4'h0, g: snk.data.g, b: 4'h0};
					tone_blue:  filtered = '{r: 4'h0, g: 4'h0, b: snk.data.b};
					default:    filtered = snk.data;  // tone_all
				endcase
			end
			default: filtered = snk.data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			src.valid <= 1'b0;
		end else if (load) begin
			src.valid <= snk.valid;
		end
	end

	// Payload follows valid, held under stall
	always_ff @(posedge clk) begin
		if (load) begin
			src.data <= filtered;
			src.sop  <= snk.sop;
			src.eop  <= snk.eop;
		end
	end

endmodule

//--- source/vision_top.sv
// Single clock pixel path; camera side has no stall, only one frame in the buffer at a time
`timescale 1ns/1ps
module vision_top import vision_pkg::*; #(
	parameter int H_PIXELS = 640,
	parameter int V_LINES  = 480
) (
	input  logic        clk,
	input  logic        reset,
	input  cam_bus_t    cam,
	input  logic [3:0]  key,
	input  freq_flag_t  freq_flag,
	output pix_stream_t pix_out,
	input  logic        pix_ready
);
	localparam int DEPTH = H_PIXELS * V_LINES;
	localparam int AW    = $clog2(DEPTH);

	logic          wr_en;
	logic [AW-1:0] wr_addr;
	pixel_t        wr_pixel;
	logic          frame_done;
	logic          rd_en;
	logic [AW-1:0] rd_addr;
	pixel_t        rd_pixel;
	pix_stream_t   gen_stream;  // Reader to filter
	logic          gen_ready;
	filter_mode_t  mode;

	pixel_capture #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) pixel_capture_inst (
		.clk(clk), .reset(reset), .cam(cam),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
		.frame_done(frame_done)
	);

	frame_buffer #(.DEPTH(DEPTH)) frame_buffer_inst (
		.clk(clk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_pixel(rd_pixel)
	);

	address_generator #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) address_generator_inst (
		.clk(clk), .reset(reset), .frame_done(frame_done),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_pixel(rd_pixel),
		.src(gen_stream), .ready(gen_ready)
	);

	filter_control filter_control_inst (
		.clk(clk), .reset(reset), .key(key), .mode(mode)
	);

	filter_select filter_select_inst (
		.clk(clk), .reset(reset), .mode(mode), .freq_flag(freq_flag),
		.snk(gen_stream), .snk_ready(gen_ready),
		.src(pix_out), .src_ready(pix_ready)
	);

endmodule

//--- dv/tb_clock.sv
// Free running clock from time zero; reset released on a falling edge after RESET_CYCLES edges
`timescale 1ns/1ps
module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Synchronous reset, dropped away from the active edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- dv/vision_assert.sv
// Stream protocol checks on the filter output; payload is only checked while valid is high
`timescale 1ns/1ps
module vision_assert import vision_pkg::*; (
	input logic        clk,
	input logic        reset,
	input pix_stream_t src,
	input logic        src_ready
);

	logic in_frame;  // Between a taken sop and its eop

	always_ff @(posedge clk) begin
		if (reset) begin
			in_frame <= 1'b0;
		end else if (src.valid && src_ready) begin
			if (src.eop)
				in_frame <= 1'b0;  // Frame closed
			else if (src.sop)
				in_frame <= 1'b1;
		end
	end

	// Stalled beat must not move
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		src.valid && !src_ready |=> $stable(src))
		else $error("output beat changed while stalled");

	// Nothing valid right out of reset
	reset_empty: assert property (@(posedge clk) reset |=> !src.valid)
		else $error("valid high in the cycle after reset");

	// New frame only once the old one ended
	sop_order: assert property (@(posedge clk) disable iff (reset)
		src.valid && src_ready && src.sop |-> !in_frame)
		else $error("sop taken before previous eop");

endmodule

bind filter_select vision_assert vision_assert_inst (
	.clk(clk),
	.reset(reset),
	.src(src),
	.src_ready(src_ready)
);

//--- dv/vision_tb.sv
// Uses an 8x4 frame; one frame in flight at a time, pix_ready held low between frames
`timescale 1ns/1ps
module vision_tb import vision_pkg::*; ();
	localparam int H_PIXELS = 8;
	localparam int V_LINES  = 4;
	localparam int PIXELS   = H_PIXELS * V_LINES;
	localparam int N_TESTS  = 7;
	localparam int TIMEOUT  = N_TESTS * (2 * PIXELS + 4 * PIXELS + 40);  // Bytes, beats, slack

	typedef struct packed {
		logic [3:0] press;         // Bit i set means key i pressed
		freq_flag_t flag;
		logic       backpressure;  // Random ready when set
	} test_entry_t;

	localparam test_entry_t TESTS [N_TESTS] = '{
		'{4'b0001, tone_all,   1'b0},  // Key 0, pass
		'{4'b1010, tone_red,   1'b1},  // Keys 1 and 3, lowest wins, gray
		'{4'b0100, tone_red,   1'b0},  // Invert
		'{4'b1000, tone_red,   1'b1},  // Tone
		'{4'b0000, tone_green, 1'b0},  // No key, tone stays
		'{4'b0000, tone_blue,  1'b1},
		'{4'b0000, tone_all,   1'b0}
	};

	logic         clk;
	logic         reset;
	cam_bus_t     cam;
	logic [3:0]   key;
	freq_flag_t   freq_flag;
	pix_stream_t  pix_out;
	logic         pix_ready;
	logic [31:0]  lfsr_state = 32'ha53a_26d2;
	pixel_t       exp_q [$];   // Expected output pixels, address order
	filter_mode_t cur_mode;    // Mode the model believes is active
	int           cycle_count = 0;

	tb_clock #(.PERIOD_NS(10), .RESET_CYCLES(10)) tb_clock_inst (.clk(clk), .reset(reset));

	vision_top #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) vision_top_inst (
		.clk(clk), .reset(reset), .cam(cam), .key(key), .freq_flag(freq_flag),
		.pix_out(pix_out), .pix_ready(pix_ready)
	);

	// Galois LFSR, one step per bit taken
	function automatic logic rand_bit();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic logic [3:0] rand_nibble();
		logic [3:0] v;
		v = '0;
		for (int i = 0; i < 4; i++)
			v = {v[2:0], rand_bit()};
		return v;
	endfunction

	// Lowest pressed key wins, no press keeps the mode
	function automatic filter_mode_t next_mode(logic [3:0] press, filter_mode_t cur);
		filter_mode_t m;
		m = cur;
		for (int i = 3; i >= 0; i--)
			if (press[i])
				m = filter_mode_t'(i);
		return m;
	endfunction

	// Reference model of the per-channel filter rules
	function automatic pixel_t expected_pixel(pixel_t p, filter_mode_t m, freq_flag_t f);
		pixel_t q;
		int     luma;
		q    = p;
		luma = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;  // Truncating divide
		case (m)
			filt_gray:   q = '{r: 4'(luma), g: 4'(luma), b: 4'(luma)};
			filt_invert: q = '{r: 4'(15 - int'(p.r)), g: 4'(15 - int'(p.g)),
			                   b: 4'(15 - int'(p.b))};
			filt_tone: begin
				if (f != tone_red && f != tone_all)
					q.r = 4'h0;
				if (f != tone_green && f != tone_all)
					q.g = 4'h0;
				if (f != tone_blue && f != tone_all)
					q.b = 4'h0;
			end
			default: q = p;
		endcase
		return q;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_pixel(string name, pixel_t got, pixel_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_marker(string name, logic got, logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_mode_count(string name, int got, int exp);
		if (got != exp)
			abort_run($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// One camera bus cycle
	task automatic drive_cam(logic vs, logic hr, logic [7:0] d);
		@(negedge clk);
		cam = '{vsync: vs, href: hr, data: d};
	endtask

	task automatic apply_keys(test_entry_t e);
		@(negedge clk);
		freq_flag = e.flag;
		key       = ~e.press;  // Active low
		cur_mode  = next_mode(e.press, cur_mode);
		repeat (3) @(negedge clk);  // Two sync flops plus mode register
		check_mode_count("mode", int'(vision_top_inst.mode), int'(cur_mode));
		key = 4'hF;
		repeat (5) @(negedge clk);
	endtask

	task automatic send_frame(filter_mode_t m, freq_flag_t f);
		pixel_t p;
		exp_q.delete();
		drive_cam(1'b1, 1'b0, 8'h00);  // vsync arms capture
		drive_cam(1'b1, 1'b0, 8'h00);
		drive_cam(1'b0, 1'b0, 8'h00);
		for (int y = 0; y < V_LINES; y++) begin
			for (int x = 0; x < H_PIXELS; x++) begin
				p.r = rand_nibble();
				p.g = rand_nibble();
				p.b = rand_nibble();
				exp_q.push_back(expected_pixel(p, m, f));
				drive_cam(1'b0, 1'b1, {rand_nibble(), p.r});  // Upper nibble ignored
				drive_cam(1'b0, 1'b1, {p.g, p.b});
			end
			drive_cam(1'b0, 1'b0, 8'h00);  // Line blank
		end
	endtask

	// Beat transfers at the next rising edge when valid and ready both high here
	task automatic collect_frame(logic backpressure);
		int   beats;
		logic eop_seen;  // Latest taken beat carried eop
		beats    = 0;
		eop_seen = 1'b0;
		while (!eop_seen && beats < PIXELS) begin
			@(negedge clk);
			pix_ready = backpressure ? rand_bit() : 1'b1;
			if (pix_out.valid && pix_ready) begin
				check_pixel("pix_out.data", pix_out.data, exp_q[beats]);
				check_marker("pix_out.sop", pix_out.sop, beats == 0);
				eop_seen = pix_out.eop;
				beats++;
			end
		end
		check_mode_count("beat count", beats, PIXELS);  // Early eop cuts the frame short
		check_marker("pix_out.eop", eop_seen, 1'b1);     // Last beat closes the frame
		repeat (3) begin
			@(negedge clk);
			pix_ready = 1'b1;
			check_marker("pix_out.valid", pix_out.valid, 1'b0);  // No trailing beat
		end
		pix_ready = 1'b0;
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT)
			abort_run($sformatf("Timeout after %0d cycles, output frame never completed",
				TIMEOUT));
	end

	initial begin
		cam       = '0;
		key       = 4'hF;
		freq_flag = tone_all;
		pix_ready = 1'b0;
		cur_mode  = filt_pass;  // Reset mode
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		for (int i = 0; i < N_TESTS; i++) begin
			apply_keys(TESTS[i]);
			send_frame(cur_mode, TESTS[i].flag);
			collect_frame(TESTS[i].backpressure);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

//--- project.f
source/vision_pkg.sv
source/pixel_capture.sv
source/frame_buffer.sv
source/address_generator.sv
source/filter_control.sv
source/filter_select.sv
source/vision_top.sv
dv/tb_clock.sv
dv/vision_assert.sv
dv/vision_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module vision_tb -f project.f --Mdir obj_dir -o vision_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/vision_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
